//--- vctrl_golden.txt
# test instr rs1 id hold accept kind(0 unit,1 cfg,2 csr) data unit vl vstart vsew vlmul
# all values hex, data for cfg and csr lines, unit..vlmul for unit lines
rd_vtype        C21020F3 0  1 0 1 2 80000000 0 0  0 0 0
rd_vl           C20020F3 0  2 0 1 2 0        0 0  0 0 0
rd_vlenb        C22020F3 0  3 0 1 2 20       0 0  0 0 0
vop_rej_reset   022080D7 0  4 0 0 0 0        0 0  0 0 0
cfg_e32m1       010170D7 5  5 0 1 1 5        0 0  0 0 0
cfg_e8m2        001170D7 64 6 0 1 1 40       0 0  0 0 0
cfg_e16mf2      00F070D7 0  7 0 1 1 8        0 0  0 0 0
cfg_keep_ok     01007057 0  8 0 1 1 8        0 0  0 0 0
vop_vfu         022080D7 0  9 0 1 0 0        0 8  0 2 0
csrrw_vstart    008110F3 3  a 0 1 2 0        0 0  0 0 0
csrrs_vstart    008120F3 4  b 0 1 2 3        0 0  0 0 0
csrrc_vstart    008130F3 1  c 0 1 2 7        0 0  0 0 0
rd_vstart       008020F3 0  d 0 1 2 6        0 0  0 0 0
vop_lsu_hold    02055207 0  e 1 1 0 0        1 8  6 1 0
rd_vstart_clr   008020F3 0  f 0 1 2 0        0 0  0 0 0
vop_sld_hold    3A20C0D7 0  0 1 1 0 0        2 8  0 2 0
cfg_e64_ill     018170D7 5  1 0 1 1 0        0 0  0 0 0
vop_rej_vill    022080D7 0  2 0 0 0 0        0 0  0 0 0
rd_vtype_ill    C21020F3 0  3 0 1 2 80000000 0 0  0 0 0
cfg_e8m1        000170D7 a  4 0 1 1 a        0 0  0 0 0
cfg_lmul_res    004170D7 5  5 0 1 1 0        0 0  0 0 0
cfg_e8m1_max    000170D7 28 6 0 1 1 20       0 0  0 0 0
cfg_keep_bad    00807057 0  7 0 1 1 0        0 0  0 0 0
rd_vl_ill       C20020F3 0  8 0 1 2 0        0 0  0 0 0
cfg_e16m4       00A170D7 32 9 0 1 1 32       0 0  0 0 0
vop_vfu_hold    022080D7 0  a 1 1 0 0        0 32 0 1 2
csr_vxsat_ill   009020F3 0  b 0 0 2 0        0 0  0 0 0
lsu_e64_ill     02057207 0  c 0 0 0 0        0 0  0 0 0

//--- vctrl.f
vctrl_pkg.sv
vctrl_req_if.sv
vctrl_decoder.sv
vctrl_issue.sv
vctrl_csr_unit.sv
vctrl_retire.sv
vctrl_top.sv
vctrl_chk.sv
vctrl_tb.sv

//--- Makefile
# Verilator simulation of the vector controller
TOP = vctrl_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails when the run fails"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --assert --timing --timescale 1ns/1ps --top-module $(TOP) -f vctrl.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TESTBENCH FAILED" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- vctrl_tb.sv
`timescale 1ns/1ps
// Vector controller testbench
// Replays the golden instruction list through the controller and checks
// acceptance, write-back results and dispatch to the execution units
module vctrl_tb;

  localparam int TIMEOUT = 50;

  logic                        clk_i;
  logic                        rst_i;
  logic                        issue_valid_i;
  logic                        issue_ready_o;
  logic [vctrl_pkg::XLEN-1:0]  issue_instr_i;
  logic [vctrl_pkg::XLEN-1:0]  issue_rs1_i;
  logic [vctrl_pkg::ID_W-1:0]  issue_id_i;
  logic                        issue_accept_o;
  logic                        issue_writeback_o;
  logic                        vfu_ready_i;
  logic                        vlsu_ready_i;
  logic                        vsldu_ready_i;
  logic                        unit_req_valid_o;
  logic [1:0]                  unit_sel_o;
  logic [vctrl_pkg::XLEN-1:0]  unit_instr_o;
  logic [vctrl_pkg::ID_W-1:0]  unit_id_o;
  logic [vctrl_pkg::VL_W-1:0]  unit_vl_o;
  logic [vctrl_pkg::VL_W-1:0]  unit_vstart_o;
  logic [2:0]                  unit_vsew_o;
  logic [2:0]                  unit_vlmul_o;
  logic                        result_valid_o;
  logic [vctrl_pkg::ID_W-1:0]  result_id_o;
  logic [4:0]                  result_rd_o;
  logic [vctrl_pkg::XLEN-1:0]  result_data_o;

  // One golden line
  string       test;
  logic [31:0] instr, rs1_val, id, hold, exp_acc, exp_kind, exp_data;
  logic [31:0] exp_unit, exp_vl, exp_vstart, exp_vsew, exp_vlmul;

  int checks;
  int errors;
  bit timed_out;

  vctrl_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever begin
      #5 clk_i = ~clk_i;
    end
  end

  task automatic check_value(input string name, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("FAILED %s %s: expected %h, actual %h", name, field, expected, actual);
    end
  endtask

  // Only the target unit is throttled, the others stay ready
  task automatic drive_ready(input logic [1:0] unit, input logic level);
    vfu_ready_i   = (unit == vctrl_pkg::UNIT_VFU) ? level : 1'b1;
    vlsu_ready_i  = (unit == vctrl_pkg::UNIT_LSU) ? level : 1'b1;
    vsldu_ready_i = (unit == vctrl_pkg::UNIT_SLD) ? level : 1'b1;
  endtask

  // Called on a falling edge, samples 1 ns later
  task automatic wait_valid(input string name, input logic dispatch);
    int   n;
    logic seen;
    n = 0;
    #1;
    seen = dispatch ? unit_req_valid_o : result_valid_o;
    while (!seen && n < TIMEOUT) begin
      @(negedge clk_i);
      #1;
      n++;
      seen = dispatch ? unit_req_valid_o : result_valid_o;
    end
    if (!seen) begin
      timed_out = 1'b1;
      errors++;
      $display("%s: timed out after %0d cycles waiting for %s", name, TIMEOUT,
               dispatch ? "a unit dispatch" : "a result");
    end
  endtask

  ////////////////////
  // One instruction
  ////////////////////

  task automatic run_test();
    int gap;
    @(negedge clk_i);
    issue_valid_i = 1'b1;
    issue_instr_i = instr;
    issue_rs1_i   = rs1_val;
    issue_id_i    = id[vctrl_pkg::ID_W-1:0];
    if (hold[0]) begin
      drive_ready(exp_unit[1:0], 1'b0);
    end
    #1;
    check_value(test, "ready", 32'd1, 32'(issue_ready_o));
    check_value(test, "accept", exp_acc, 32'(issue_accept_o));
    check_value(test, "writeback", 32'(exp_acc[0] && exp_kind != 32'd0),
                32'(issue_writeback_o));
    @(negedge clk_i);
    issue_valid_i = 1'b0;
    if (!exp_acc[0]) begin
      #1;
      check_value(test, "ready after reject", 32'd1, 32'(issue_ready_o));
      check_value(test, "stray dispatch", 32'd0, 32'(unit_req_valid_o));
    end else if (exp_kind != 32'd0) begin
      wait_valid(test, 1'b0);
      if (!timed_out) begin
        check_value(test, "data", exp_data, result_data_o);
        check_value(test, "id", id, 32'(result_id_o));
        check_value(test, "rd", 32'(instr[11:7]), 32'(result_rd_o));
      end
    end else begin
      if (hold[0]) begin
        gap = int'($urandom_range(6, 1));
        repeat (gap) begin
          #1;
          check_value(test, "dispatch under hold", 32'd0, 32'(unit_req_valid_o));
          check_value(test, "ready under hold", 32'd0, 32'(issue_ready_o));
          @(negedge clk_i);
        end
        drive_ready(exp_unit[1:0], 1'b1);
      end
      wait_valid(test, 1'b1);
      if (!timed_out) begin
        check_value(test, "unit", exp_unit, 32'(unit_sel_o));
        check_value(test, "instr", instr, unit_instr_o);
        check_value(test, "id", id, 32'(unit_id_o));
        check_value(test, "vl", exp_vl, 32'(unit_vl_o));
        check_value(test, "vstart", exp_vstart, 32'(unit_vstart_o));
        check_value(test, "vsew", exp_vsew, 32'(unit_vsew_o));
        check_value(test, "vlmul", exp_vlmul, 32'(unit_vlmul_o));
        @(negedge clk_i);
        #1;
        check_value(test, "single dispatch", 32'd0, 32'(unit_req_valid_o));
      end
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int    fd;
    int    n;
    string line;
    checks        = 0;
    errors        = 0;
    timed_out     = 1'b0;
    rst_i         = 1'b1;
    issue_valid_i = 1'b0;
    issue_instr_i = '0;
    issue_rs1_i   = '0;
    issue_id_i    = '0;
    vfu_ready_i   = 1'b1;
    vlsu_ready_i  = 1'b1;
    vsldu_ready_i = 1'b1;
    void'($urandom(32'hb781));
    repeat (2) @(negedge clk_i);
    rst_i = 1'b0;

    fd = $fopen("vctrl_golden.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the golden file vctrl_golden.txt");
    end else begin
      while (!timed_out && $fgets(line, fd) > 0) begin
        if (line.len() < 2 || line[0] == "#") begin
          continue;
        end
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h", test, instr, rs1_val,
                    id, hold, exp_acc, exp_kind, exp_data, exp_unit, exp_vl, exp_vstart,
                    exp_vsew, exp_vlmul);
        if (n != 13) begin
          errors++;
          $display("Golden line has the wrong number of columns: %s", line);
        end else begin
          run_test();
        end
      end
      $fclose(fd);
    end

    $display("Checks %0d, errors %0d, assertion failures %0d", checks, errors,
             UUT.i_chk.assert_fails);
    if (errors == 0 && UUT.i_chk.assert_fails == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- vctrl_chk.sv
`timescale 1ns/1ps
// Controller protocol checks
// Watches the result pulse, unit dispatch and the state after reset
module vctrl_chk (
  input logic       clk_i,
  input logic       rst_i,
  input logic       result_valid_i,
  input logic       unit_req_valid_i,
  input logic [1:0] unit_sel_i,
  input logic       vfu_ready_i,
  input logic       vlsu_ready_i,
  input logic       vsldu_ready_i
);

  int   assert_fails;
  logic sel_ready;

  initial begin
    assert_fails = 0;
  end

  assign sel_ready = (unit_sel_i == vctrl_pkg::UNIT_LSU) ? vlsu_ready_i :
                     (unit_sel_i == vctrl_pkg::UNIT_SLD) ? vsldu_ready_i : vfu_ready_i;

  // Results are single-cycle pulses
  result_pulse_a: assert property (@(posedge clk_i) disable iff (rst_i)
    result_valid_i |=> !result_valid_i)
    else begin
      assert_fails++;
      $error("result valid lasted two cycles");
    end

  dispatch_ready_a: assert property (@(posedge clk_i) disable iff (rst_i)
    unit_req_valid_i |-> sel_ready)
    else begin
      assert_fails++;
      $error("dispatch to a unit that is not ready");
    end

  // Both valids quiet right after a reset cycle
  reset_quiet_a: assert property (@(posedge clk_i)
    rst_i |=> (!result_valid_i && !unit_req_valid_i))
    else begin
      assert_fails++;
      $error("valid output high after reset");
    end

endmodule

bind vctrl_top vctrl_chk i_chk (
  .clk_i           (clk_i),
  .rst_i           (rst_i),
  .result_valid_i  (result_valid_o),
  .unit_req_valid_i(unit_req_valid_o),
  .unit_sel_i      (unit_sel_o),
  .vfu_ready_i     (vfu_ready_i),
  .vlsu_ready_i    (vlsu_ready_i),
  .vsldu_ready_i   (vsldu_ready_i)
);

//--- vctrl_top.sv
`timescale 1ns/1ps
// Vector controller top level
// Decoder, issue buffer, CSR unit and retire stage on plain core ports
module vctrl_top (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        issue_valid_i,
  output logic                        issue_ready_o,
  input  logic [vctrl_pkg::XLEN-1:0]  issue_instr_i,
  input  logic [vctrl_pkg::XLEN-1:0]  issue_rs1_i,
  input  logic [vctrl_pkg::ID_W-1:0]  issue_id_i,
  output logic                        issue_accept_o,
  output logic                        issue_writeback_o,
  input  logic                        vfu_ready_i,
  input  logic                        vlsu_ready_i,
  input  logic                        vsldu_ready_i,
  output logic                        unit_req_valid_o,
  output logic [1:0]                  unit_sel_o,
  output logic [vctrl_pkg::XLEN-1:0]  unit_instr_o,
  output logic [vctrl_pkg::ID_W-1:0]  unit_id_o,
  output logic [vctrl_pkg::VL_W-1:0]  unit_vl_o,
  output logic [vctrl_pkg::VL_W-1:0]  unit_vstart_o,
  output logic [2:0]                  unit_vsew_o,
  output logic [2:0]                  unit_vlmul_o,
  output logic                        result_valid_o,
  output logic [vctrl_pkg::ID_W-1:0]  result_id_o,
  output logic [4:0]                  result_rd_o,
  output logic [vctrl_pkg::XLEN-1:0]  result_data_o
);

  logic [vctrl_pkg::VL_W-1:0] vl, vstart;
  logic [vctrl_pkg::XLEN-1:0] vtype, pop_rs1, csr_data;
  logic                       vill, pop;
  logic [1:0]                 pop_kind;
  vctrl_pkg::vctrl_instr_u    pop_instr;
  logic [vctrl_pkg::ID_W-1:0] pop_id;

  vctrl_req_if req_if ();

  vctrl_decoder i_decoder (
    .issue_valid_i    (issue_valid_i),
    .issue_instr_i    (issue_instr_i),
    .issue_rs1_i      (issue_rs1_i),
    .issue_id_i       (issue_id_i),
    .issue_ready_i    (issue_ready_o),
    .vill_i           (vill),
    .issue_accept_o   (issue_accept_o),
    .issue_writeback_o(issue_writeback_o),
    .req              (req_if.decoder_mp)
  );

  vctrl_issue i_issue (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .req             (req_if.issue_mp),
    .vfu_ready_i     (vfu_ready_i),
    .vlsu_ready_i    (vlsu_ready_i),
    .vsldu_ready_i   (vsldu_ready_i),
    .vl_i            (vl),
    .vstart_i        (vstart),
    .vtype_i         (vtype),
    .issue_ready_o   (issue_ready_o),
    .unit_req_valid_o(unit_req_valid_o),
    .unit_sel_o      (unit_sel_o),
    .unit_instr_o    (unit_instr_o),
    .unit_id_o       (unit_id_o),
    .unit_vl_o       (unit_vl_o),
    .unit_vstart_o   (unit_vstart_o),
    .unit_vsew_o     (unit_vsew_o),
    .unit_vlmul_o    (unit_vlmul_o),
    .pop_o           (pop),
    .pop_kind_o      (pop_kind),
    .pop_instr_o     (pop_instr),
    .pop_rs1_o       (pop_rs1),
    .pop_id_o        (pop_id)
  );

  vctrl_csr_unit i_csr_unit (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .pop_i        (pop),
    .pop_kind_i   (pop_kind),
    .pop_instr_i  (pop_instr),
    .pop_rs1_i    (pop_rs1),
    .vl_o         (vl),
    .vstart_o     (vstart),
    .vtype_o      (vtype),
    .vill_o       (vill),
    .result_data_o(csr_data)
  );

  vctrl_retire i_retire (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .pop_i         (pop),
    .pop_kind_i    (pop_kind),
    .pop_instr_i   (pop_instr),
    .pop_id_i      (pop_id),
    .data_i        (csr_data),
    .result_valid_o(result_valid_o),
    .result_id_o   (result_id_o),
    .result_rd_o   (result_rd_o),
    .result_data_o (result_data_o)
  );

endmodule

//--- vctrl_retire.sv
`timescale 1ns/1ps
// Result retire
// Registers the write-back of configuration and CSR instructions and
// presents it to the core as a one-cycle pulse
module vctrl_retire (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        pop_i,
  input  logic [1:0]                  pop_kind_i,
  input  vctrl_pkg::vctrl_instr_u     pop_instr_i,
  input  logic [vctrl_pkg::ID_W-1:0]  pop_id_i,
  input  logic [vctrl_pkg::XLEN-1:0]  data_i,
  output logic                        result_valid_o,
  output logic [vctrl_pkg::ID_W-1:0]  result_id_o,
  output logic [4:0]                  result_rd_o,
  output logic [vctrl_pkg::XLEN-1:0]  result_data_o
);

  logic retire;

  // Unit operations report nothing back to the core
  assign retire = pop_i && pop_kind_i != vctrl_pkg::KIND_UNIT;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= retire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (retire) begin
      result_id_o   <= pop_id_i;
      result_rd_o   <= pop_instr_i.csr.rd;
      result_data_o <= data_i;
    end
  end

endmodule

//--- vctrl_csr_unit.sv
`timescale 1ns/1ps
// Vector CSR unit
// Holds vstart, vl and vtype, applies vsetvli and CSR accesses at the
// pop edge and forms the data that goes back to the core
module vctrl_csr_unit (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        pop_i,
  input  logic [1:0]                  pop_kind_i,
  input  vctrl_pkg::vctrl_instr_u     pop_instr_i,
  input  logic [vctrl_pkg::XLEN-1:0]  pop_rs1_i,
  output logic [vctrl_pkg::VL_W-1:0]  vl_o,
  output logic [vctrl_pkg::VL_W-1:0]  vstart_o,
  output logic [vctrl_pkg::XLEN-1:0]  vtype_o,
  output logic                        vill_o,
  output logic [vctrl_pkg::XLEN-1:0]  result_data_o
);

  localparam int unsigned PadW = vctrl_pkg::XLEN - vctrl_pkg::VL_W;

  logic [vctrl_pkg::VL_W-1:0] vstart_q, vstart_d, vl_q, vl_d;
  logic [vctrl_pkg::VL_W-1:0] vlmax_base, vlmax, wdata;
  logic [vctrl_pkg::XLEN-1:0] vtype_q, vtype_d, vlmax_x, csr_rdata;
  logic [2:0]                 vsew_new, vlmul_new, vsew_old, vlmul_old, frac_sh;
  logic signed [3:0]          sew_diff, lmul_diff;
  logic                       keep_vl, cfg_illegal;

  assign vsew_new  = pop_instr_i.cfg.vtypei[vctrl_pkg::VTYPE_VSEW_LSB +: 3];
  assign vlmul_new = pop_instr_i.cfg.vtypei[vctrl_pkg::VTYPE_VLMUL_LSB +: 3];
  assign vsew_old  = vtype_q[vctrl_pkg::VTYPE_VSEW_LSB +: 3];
  assign vlmul_old = vtype_q[vctrl_pkg::VTYPE_VLMUL_LSB +: 3];

  ////////////////////
  // vsetvli
  ////////////////////

  // Fractional LMUL codes 5..7 shift right by 3..1
  assign vlmax_base = vctrl_pkg::VLENB[vctrl_pkg::VL_W-1:0] >> vsew_new;
  assign frac_sh    = 3'd0 - vlmul_new;
  assign vlmax      = vlmul_new[2] ? (vlmax_base >> frac_sh) : (vlmax_base << vlmul_new[1:0]);
  assign vlmax_x    = {{PadW{1'b0}}, vlmax};

  assign keep_vl   = pop_instr_i.cfg.rs1 == 5'd0 && pop_instr_i.cfg.rd == 5'd0;
  // vlmul is a signed exponent, vsew never exceeds e32 here
  assign sew_diff  = $signed({1'b0, vsew_new}) - $signed({1'b0, vsew_old});
  assign lmul_diff = $signed({vlmul_new[2], vlmul_new}) - $signed({vlmul_old[2], vlmul_old});

  assign cfg_illegal = vsew_new > vctrl_pkg::EW_32 ||
                       vlmul_new inside {vctrl_pkg::LMUL_RES, vctrl_pkg::LMUL_F8} ||
                       (keep_vl && sew_diff != lmul_diff);

  assign wdata = pop_rs1_i[vctrl_pkg::VL_W-1:0];

  always_comb begin
    vstart_d = vstart_q;
    vl_d     = vl_q;
    vtype_d  = vtype_q;
    if (pop_i) begin
      case (pop_kind_i)
        vctrl_pkg::KIND_UNIT: vstart_d = '0;
        vctrl_pkg::KIND_CFG: begin
          if (cfg_illegal) begin
            vtype_d = vctrl_pkg::VTYPE_RESET;
            vl_d    = '0;
          end else begin
            vtype_d = {{(vctrl_pkg::XLEN-11){1'b0}}, pop_instr_i.cfg.vtypei};
            if (!keep_vl) begin
              // Strip mining when rs1 names a register, else vlmax
              if (pop_instr_i.cfg.rs1 != 5'd0 && pop_rs1_i < vlmax_x) begin
                vl_d = wdata;
              end else begin
                vl_d = vlmax;
              end
            end
          end
        end
        default: begin
          if (pop_instr_i.csr.addr == vctrl_pkg::CSR_VSTART) begin
            case (pop_instr_i.csr.funct3)
              vctrl_pkg::F3_CSRRW: vstart_d = wdata;
              vctrl_pkg::F3_CSRRS: vstart_d = vstart_q | wdata;
              vctrl_pkg::F3_CSRRC: vstart_d = vstart_q & ~wdata;
              default:             vstart_d = vstart_q;
            endcase
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      vstart_q <= '0;
      vl_q     <= '0;
      vtype_q  <= vctrl_pkg::VTYPE_RESET;
    end else begin
      vstart_q <= vstart_d;
      vl_q     <= vl_d;
      vtype_q  <= vtype_d;
    end
  end

  ////////////////////
  // Read back
  ////////////////////

  // CSR reads see the value before this access
  always_comb begin
    case (pop_instr_i.csr.addr)
      vctrl_pkg::CSR_VSTART: csr_rdata = {{PadW{1'b0}}, vstart_q};
      vctrl_pkg::CSR_VL:     csr_rdata = {{PadW{1'b0}}, vl_q};
      vctrl_pkg::CSR_VTYPE:  csr_rdata = vtype_q;
      vctrl_pkg::CSR_VLENB:  csr_rdata = vctrl_pkg::VLENB;
      default:               csr_rdata = '0;
    endcase
    if (pop_kind_i == vctrl_pkg::KIND_CFG) begin
      result_data_o = {{PadW{1'b0}}, vl_d};
    end else if (pop_instr_i.csr.rd == 5'd0) begin
      result_data_o = '0;
    end else begin
      result_data_o = csr_rdata;
    end
  end

  assign vl_o     = vl_q;
  assign vstart_o = vstart_q;
  assign vtype_o  = vtype_q;
  assign vill_o   = vtype_q[vctrl_pkg::VTYPE_VILL_BIT];

endmodule

//--- vctrl_issue.sv
`timescale 1ns/1ps
// Request issue
// One-entry buffer that holds a unit operation until its unit is ready
// and hands configuration and CSR entries to the CSR unit at once
module vctrl_issue (
  input  logic                        clk_i,
  input  logic                        rst_i,
  vctrl_req_if.issue_mp               req,
  input  logic                        vfu_ready_i,
  input  logic                        vlsu_ready_i,
  input  logic                        vsldu_ready_i,
  input  logic [vctrl_pkg::VL_W-1:0]  vl_i,
  input  logic [vctrl_pkg::VL_W-1:0]  vstart_i,
  input  logic [vctrl_pkg::XLEN-1:0]  vtype_i,
  output logic                        issue_ready_o,
  output logic                        unit_req_valid_o,
  output logic [1:0]                  unit_sel_o,
  output logic [vctrl_pkg::XLEN-1:0]  unit_instr_o,
  output logic [vctrl_pkg::ID_W-1:0]  unit_id_o,
  output logic [vctrl_pkg::VL_W-1:0]  unit_vl_o,
  output logic [vctrl_pkg::VL_W-1:0]  unit_vstart_o,
  output logic [2:0]                  unit_vsew_o,
  output logic [2:0]                  unit_vlmul_o,
  output logic                        pop_o,
  output logic [1:0]                  pop_kind_o,
  output vctrl_pkg::vctrl_instr_u     pop_instr_o,
  output logic [vctrl_pkg::XLEN-1:0]  pop_rs1_o,
  output logic [vctrl_pkg::ID_W-1:0]  pop_id_o
);

  logic                       full_q;
  logic [1:0]                 kind_q;
  logic [1:0]                 unit_q;
  logic [2:0]                 eew_q;
  vctrl_pkg::vctrl_instr_u    instr_q;
  logic [vctrl_pkg::XLEN-1:0] rs1_q;
  logic [vctrl_pkg::ID_W-1:0] id_q;
  logic                       unit_ready;
  logic                       is_unit;
  logic                       stall;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (req.valid) begin
      full_q <= 1'b1;
    end else if (pop_o) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req.valid) begin
      kind_q  <= req.kind;
      unit_q  <= req.unit;
      eew_q   <= req.eew;
      instr_q <= req.instr;
      rs1_q   <= req.rs1;
      id_q    <= req.id;
    end
  end

  always_comb begin
    case (unit_q)
      vctrl_pkg::UNIT_LSU: unit_ready = vlsu_ready_i;
      vctrl_pkg::UNIT_SLD: unit_ready = vsldu_ready_i;
      default:             unit_ready = vfu_ready_i;
    endcase
  end

  // Only unit operations can be held back
  assign is_unit       = kind_q == vctrl_pkg::KIND_UNIT;
  assign stall         = full_q && is_unit && !unit_ready;
  assign pop_o         = full_q && !stall;
  assign issue_ready_o = !full_q || pop_o;

  ////////////////////
  // Dispatch
  ////////////////////

  assign unit_req_valid_o = pop_o && is_unit;
  assign unit_sel_o       = unit_q;
  assign unit_instr_o     = instr_q;
  assign unit_id_o        = id_q;
  assign unit_vl_o        = vl_i;
  assign unit_vstart_o    = vstart_i;
  // Loads and stores keep their own element width
  assign unit_vsew_o      = (unit_q == vctrl_pkg::UNIT_LSU) ? eew_q :
                            vtype_i[vctrl_pkg::VTYPE_VSEW_LSB +: 3];
  assign unit_vlmul_o     = vtype_i[vctrl_pkg::VTYPE_VLMUL_LSB +: 3];

  assign pop_kind_o  = kind_q;
  assign pop_instr_o = instr_q;
  assign pop_rs1_o   = rs1_q;
  assign pop_id_o    = id_q;

endmodule

//--- vctrl_decoder.sv
`timescale 1ns/1ps
// Vector instruction decoder
// Sorts an offered word into configuration, CSR access or unit operation,
// checks legality and answers accept and writeback in the same cycle
module vctrl_decoder (
  input  logic                       issue_valid_i,
  input  logic [vctrl_pkg::XLEN-1:0] issue_instr_i,
  input  logic [vctrl_pkg::XLEN-1:0] issue_rs1_i,
  input  logic [vctrl_pkg::ID_W-1:0] issue_id_i,
  input  logic                       issue_ready_i,
  input  logic                       vill_i,
  output logic                       issue_accept_o,
  output logic                       issue_writeback_o,
  vctrl_req_if.decoder_mp            req
);

  vctrl_pkg::vctrl_instr_u instr;
  logic [5:0]              funct6;
  logic                    legal;
  logic [1:0]              kind;
  logic [1:0]              unit;
  logic [2:0]              eew;

  assign instr  = issue_instr_i;
  // Same bit positions for every OP-V format
  assign funct6 = issue_instr_i[31:26];

  always_comb begin
    legal = 1'b0;
    kind  = vctrl_pkg::KIND_UNIT;
    unit  = vctrl_pkg::UNIT_VFU;
    eew   = vctrl_pkg::EW_8;
    case (instr.cfg.opcode)
      vctrl_pkg::OPC_OPV: begin
        legal = 1'b1;
        if (instr.cfg.funct3 == vctrl_pkg::F3_OPCFG && !instr.cfg.top) begin
          kind = vctrl_pkg::KIND_CFG;
        end else if (funct6 == vctrl_pkg::F6_SLIDEUP || funct6 == vctrl_pkg::F6_SLIDEDOWN) begin
          unit = vctrl_pkg::UNIT_SLD;
        end
      end
      vctrl_pkg::OPC_LOADFP, vctrl_pkg::OPC_STOREFP: begin
        legal = 1'b1;
        unit  = vctrl_pkg::UNIT_LSU;
        // Width field selects the memory element width
        case (instr.cfg.funct3)
          3'd0:    eew = vctrl_pkg::EW_8;
          3'd5:    eew = vctrl_pkg::EW_16;
          3'd6:    eew = vctrl_pkg::EW_32;
          default: legal = 1'b0;
        endcase
      end
      vctrl_pkg::OPC_SYSTEM: begin
        kind  = vctrl_pkg::KIND_CSR;
        legal = (instr.csr.funct3 inside {vctrl_pkg::F3_CSRRW, vctrl_pkg::F3_CSRRS,
                                          vctrl_pkg::F3_CSRRC}) &&
                (instr.csr.addr inside {vctrl_pkg::CSR_VSTART, vctrl_pkg::CSR_VL,
                                        vctrl_pkg::CSR_VTYPE, vctrl_pkg::CSR_VLENB});
      end
      default: legal = 1'b0;
    endcase
  end

  // Unit operations need a valid vtype
  assign issue_accept_o    = legal && (kind != vctrl_pkg::KIND_UNIT || !vill_i);
  assign issue_writeback_o = issue_accept_o && kind != vctrl_pkg::KIND_UNIT;

  assign req.valid = issue_valid_i && issue_ready_i && issue_accept_o;
  assign req.kind  = kind;
  assign req.unit  = unit;
  assign req.eew   = eew;
  assign req.instr = instr;
  assign req.rs1   = issue_rs1_i;
  assign req.id    = issue_id_i;

endmodule

//--- vctrl_req_if.sv
`timescale 1ns/1ps
// Decoded request bundle
// Carries one accepted instruction from the decoder into the issue buffer
interface vctrl_req_if;

  // Strobe for one cycle when the core hands over an accepted instruction
  logic                          valid;
  logic [1:0]                    kind;
  logic [1:0]                    unit;
  // Element width of a load or store
  logic [2:0]                    eew;
  vctrl_pkg::vctrl_instr_u       instr;
  logic [vctrl_pkg::XLEN-1:0]    rs1;
  logic [vctrl_pkg::ID_W-1:0]    id;

  modport decoder_mp (
    output valid, kind, unit, eew, instr, rs1, id
  );

  modport issue_mp (
    input valid, kind, unit, eew, instr, rs1, id
  );

endinterface

//--- vctrl_pkg.sv
// Vector controller package
// Sizes, opcode and CSR constants, kind and unit codes, and the
// instruction word with its configuration and CSR views
package vctrl_pkg;

  //////////////////////
  // Sizes
  //////////////////////

  localparam int unsigned XLEN  = 32;
  localparam int unsigned VLEN  = 256;
  localparam logic [XLEN-1:0] VLENB = XLEN'(VLEN / 8);
  // Wide enough for VLENB * 8 elements
  localparam int unsigned VL_W  = 9;
  localparam int unsigned ID_W  = 4;

  // vtype field positions
  localparam int unsigned VTYPE_VILL_BIT  = 31;
  localparam int unsigned VTYPE_VSEW_LSB  = 3;
  localparam int unsigned VTYPE_VLMUL_LSB = 0;
  localparam logic [XLEN-1:0] VTYPE_RESET = XLEN'(1) << VTYPE_VILL_BIT;

  //////////////////////
  // Encodings
  //////////////////////

  localparam logic [6:0] OPC_OPV     = 7'h57;
  localparam logic [6:0] OPC_SYSTEM  = 7'h73;
  localparam logic [6:0] OPC_LOADFP  = 7'h07;
  localparam logic [6:0] OPC_STOREFP = 7'h27;

  localparam logic [2:0] F3_OPCFG = 3'b111;
  localparam logic [2:0] F3_CSRRW = 3'b001;
  localparam logic [2:0] F3_CSRRS = 3'b010;
  localparam logic [2:0] F3_CSRRC = 3'b011;

  localparam logic [5:0] F6_SLIDEUP   = 6'b001110;
  localparam logic [5:0] F6_SLIDEDOWN = 6'b001111;

  localparam logic [11:0] CSR_VSTART = 12'h008;
  localparam logic [11:0] CSR_VL     = 12'hC20;
  localparam logic [11:0] CSR_VTYPE  = 12'hC21;
  localparam logic [11:0] CSR_VLENB  = 12'hC22;

  // Instruction kind and target unit
  localparam logic [1:0] KIND_UNIT = 2'd0;
  localparam logic [1:0] KIND_CFG  = 2'd1;
  localparam logic [1:0] KIND_CSR  = 2'd2;

  localparam logic [1:0] UNIT_VFU = 2'd0;
  localparam logic [1:0] UNIT_LSU = 2'd1;
  localparam logic [1:0] UNIT_SLD = 2'd2;

  // vsew and vlmul codes
  localparam logic [2:0] EW_8     = 3'd0;
  localparam logic [2:0] EW_16    = 3'd1;
  localparam logic [2:0] EW_32    = 3'd2;
  localparam logic [2:0] LMUL_RES = 3'd4;
  localparam logic [2:0] LMUL_F8  = 3'd5;

  //////////////////////
  // Instruction word
  //////////////////////

  typedef union packed {
    struct packed {
      logic        top;
      logic [10:0] vtypei;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } cfg;
    struct packed {
      logic [11:0] addr;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } csr;
  } vctrl_instr_u;

endpackage
